// ==== verilog/lcdPkg.sv ====
package lcdPkg;

    // instruction bytes of the HD44780-style controller
    typedef enum logic [7:0] {
        cmdClear       = 8'h01,
        cmdDisplayOn   = 8'h0C,
        cmdFunctionSet = 8'h38
    } lcdCmd_t;

    // 8-bit bus and two lines, display on with cursor off, then clear
    localparam int initCount = 3;

    // quiet gap between frames
    // a real panel wants about 200
    localparam int holdCycles = 20;

    // main controller states
    typedef enum logic [2:0] {
        Idle,
        Init,
        Clear,
        Select,
        Load,
        Show,
        Place,
        Hold
    } seqState_t;

endpackage

// ==== verilog/glyphPkg.sv ====
package glyphPkg;

    // one image is a 4x2 block of custom characters
    localparam int charsPerImage = 8;
    localparam int rowsPerChar   = 8;
    localparam int imageCount    = 4;
    localparam int romWords      = imageCount * charsPerImage;

    // loader sends an address and the rows of each char
    localparam int loadBytes  = charsPerImage * (rowsPerChar + 1);
    // placer sends a cursor command and a code per char
    localparam int placeBytes = charsPerImage * 2;

    localparam logic [7:0] cgramBase  = 8'h40;
    localparam logic [7:0] ddramLine0 = 8'h80;
    localparam logic [7:0] ddramLine1 = 8'hC0;
    localparam logic [7:0] halfColumn = 8'd4;

    // order matches the ROM image index
    typedef enum logic [1:0] {imgSad, imgHappy, imgEnergy, imgFood} image_t;

    // row 0 sits in bits 63:56
    typedef logic [63:0] glyph_t;

endpackage

// ==== verilog/lcdStepIf.sv ====
interface lcdStepIf;
    import glyphPkg::*;

    logic       start;
    image_t     image;
    logic       half;
    logic       rs;
    logic [7:0] data;
    logic       strobe;
    logic       done;

    modport sequencer (
        output start, image, half,
        input  rs, data, strobe, done
    );

    modport engine (
        input  start, image, half,
        output rs, data, strobe, done
    );

endinterface

// ==== verilog/glyphRom.sv ====
module glyphRom (
    input  glyphPkg::image_t image,
    input  logic [2:0]       charIndex,
    output glyphPkg::glyph_t glyph
);
    import glyphPkg::*;

    // four images of eight characters each
    glyph_t romData [romWords];

    initial begin
        $readmemh("glyphs.mem", romData);
    end

    // word number is image * 8 + character
    assign glyph = romData[{image, charIndex}];

endmodule

// ==== verilog/cgramLoader.sv ====
module cgramLoader (
    input  logic             clk_16ms,
    input  logic             reset,
    lcdStepIf.engine         step,
    output glyphPkg::image_t image,
    output logic [2:0]       charIndex,
    input  glyphPkg::glyph_t glyph
);
    import glyphPkg::*;

    logic       busy;
    logic [2:0] charCount;
    // slot 0 is the address command, 1 to 8 are rows 0 to 7
    logic [3:0] rowCount;
    logic [2:0] rowSel;
    logic [7:0] rowByte;

    always_ff @(posedge clk_16ms) begin
        if (!reset) begin
            busy      <= 1'b0;
            charCount <= 3'd0;
            rowCount  <= 4'd0;
        end else if (!busy) begin
            if (step.start) begin
                busy      <= 1'b1;
                charCount <= 3'd0;
                rowCount  <= 4'd0;
            end
        end else if (step.done) begin
            busy <= 1'b0;
        end else if (rowCount == 4'(rowsPerChar)) begin
            rowCount  <= 4'd0;
            charCount <= charCount + 3'd1;
        end else begin
            rowCount <= rowCount + 4'd1;
        end
    end

    assign image     = step.image;
    assign charIndex = charCount;

    // pick the pattern row, top byte first
    assign rowSel  = rowCount[2:0] - 3'd1;
    assign rowByte = glyph[8 * (7 - int'(rowSel)) +: 8];

    assign step.strobe = busy;
    assign step.rs     = (rowCount != 4'd0);
    assign step.data   = (rowCount == 4'd0) ? cgramBase + {2'b00, charCount, 3'b000} : rowByte;
    assign step.done   = busy && (charCount == 3'(charsPerImage - 1))
                         && (rowCount == 4'(rowsPerChar));

    // an accepted start yields exactly one full run ending in done
    assert property (@(posedge clk_16ms) disable iff (!reset)
        (step.start && !busy) |-> ##loadBytes (step.done && step.strobe));

endmodule

// ==== verilog/cursorPlacer.sv ====
module cursorPlacer (
    input logic      clk_16ms,
    input logic      reset,
    lcdStepIf.engine step
);
    import glyphPkg::*;

    logic       busy;
    logic [2:0] charCount;
    // low for the cursor command, high for the character code
    logic       codePhase;
    logic [7:0] lineBase;
    logic [7:0] cursorCmd;

    always_ff @(posedge clk_16ms) begin
        if (!reset) begin
            busy      <= 1'b0;
            charCount <= 3'd0;
            codePhase <= 1'b0;
        end else if (!busy) begin
            if (step.start) begin
                busy      <= 1'b1;
                charCount <= 3'd0;
                codePhase <= 1'b0;
            end
        end else if (step.done) begin
            busy <= 1'b0;
        end else begin
            codePhase <= ~codePhase;
            if (codePhase) begin
                charCount <= charCount + 3'd1;
            end
        end
    end

    // chars 0-3 on line 0, 4-7 on line 1, four columns each
    assign lineBase  = charCount[2] ? ddramLine1 : ddramLine0;
    assign cursorCmd = lineBase + {6'd0, charCount[1:0]} + (step.half ? halfColumn : 8'h00);

    assign step.strobe = busy;
    assign step.rs     = codePhase;
    assign step.data   = codePhase ? {5'd0, charCount} : cursorCmd;
    assign step.done   = busy && codePhase && (charCount == 3'(charsPerImage - 1));

endmodule

// ==== verilog/lcdSequencer.sv ====
module lcdSequencer (
    input  logic        clk_16ms,
    input  logic        reset,
    input  logic        moodSel,
    input  logic        needSel,
    lcdStepIf.sequencer loadStep,
    lcdStepIf.sequencer placeStep,
    output logic        rs,
    output logic        rw,
    output logic        enable,
    output logic [7:0]  data
);
    import lcdPkg::*;
    import glyphPkg::*;

    seqState_t  state;
    logic [1:0] initIdx;
    logic [$clog2(holdCycles)-1:0] holdCount;
    logic       half;
    image_t     curImage;
    image_t     selImage;
    lcdCmd_t    initCmd;
    logic       nextEnable;
    logic       nextRs;
    logic [7:0] nextData;

    // half 0 shows the mood, half 1 the need
    assign selImage = half ? (needSel ? imgFood : imgEnergy)
                           : (moodSel ? imgHappy : imgSad);

    always_comb begin
        case (initIdx)
            2'd0:    initCmd = cmdFunctionSet;
            2'd1:    initCmd = cmdDisplayOn;
            default: initCmd = cmdClear;
        endcase
    end

    always_ff @(posedge clk_16ms) begin
        if (!reset) begin
            state     <= Idle;
            initIdx   <= 2'd0;
            holdCount <= '0;
            half      <= 1'b0;
        end else begin
            case (state)
                Idle: state <= Init;
                Init: begin
                    initIdx <= initIdx + 2'd1;
                    if (initIdx == 2'(initCount - 1)) begin
                        state <= Clear;
                    end
                end
                Clear:  state <= Select;
                Select: state <= Load;
                Load:   if (loadStep.done) state <= Show;
                Show:   state <= Place;
                Place:  if (placeStep.done) state <= Hold;
                Hold: begin
                    if (holdCount == ($bits(holdCount))'(holdCycles - 1)) begin
                        holdCount <= '0;
                        half      <= ~half;
                        state     <= Clear;
                    end else begin
                        holdCount <= holdCount + 1'b1;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    // image for the coming load
    always_ff @(posedge clk_16ms) begin
        if (state == Select) begin
            curImage <= selImage;
        end
    end

    assign loadStep.start  = (state == Select);
    assign loadStep.image  = curImage;
    assign loadStep.half   = half;
    assign placeStep.start = (state == Show);
    assign placeStep.image = curImage;
    assign placeStep.half  = half;

    // byte source for the next bus cycle
    always_comb begin
        nextEnable = 1'b0;
        nextRs     = 1'b0;
        nextData   = 8'h00;
        case (state)
            Init: begin
                nextEnable = 1'b1;
                nextData   = initCmd;
            end
            Clear: begin
                nextEnable = 1'b1;
                nextData   = cmdClear;
            end
            Show: begin
                nextEnable = 1'b1;
                nextData   = cmdDisplayOn;
            end
            Load: begin
                nextEnable = loadStep.strobe;
                nextRs     = loadStep.rs;
                nextData   = loadStep.data;
            end
            Place: begin
                nextEnable = placeStep.strobe;
                nextRs     = placeStep.rs;
                nextData   = placeStep.data;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_16ms) begin
        if (!reset) begin
            enable <= 1'b0;
            rs     <= 1'b0;
            data   <= 8'h00;
        end else begin
            enable <= nextEnable;
            rs     <= nextRs;
            data   <= nextData;
        end
    end

    // write-only bus
    assign rw = 1'b0;

    // an engine byte outside its own state would be lost or leak into Hold
    assert property (@(posedge clk_16ms) disable iff (!reset)
        loadStep.strobe |-> (state == Load));
    assert property (@(posedge clk_16ms) disable iff (!reset)
        placeStep.strobe |-> (state == Place));

endmodule

// ==== verilog/lcdTop.sv ====
module lcdTop (
    input  logic       clk_16ms,
    input  logic       reset,
    input  logic       moodSel,
    input  logic       needSel,
    output logic       rs,
    output logic       rw,
    output logic       enable,
    output logic [7:0] data
);
    import glyphPkg::*;

    image_t     romImage;
    logic [2:0] romChar;
    glyph_t     romGlyph;

    lcdStepIf loadStep ();
    lcdStepIf placeStep ();

    lcdSequencer sequencer (
        .clk_16ms  (clk_16ms),
        .reset     (reset),
        .moodSel   (moodSel),
        .needSel   (needSel),
        .loadStep  (loadStep.sequencer),
        .placeStep (placeStep.sequencer),
        .rs        (rs),
        .rw        (rw),
        .enable    (enable),
        .data      (data)
    );

    cgramLoader loader (
        .clk_16ms  (clk_16ms),
        .reset     (reset),
        .step      (loadStep.engine),
        .image     (romImage),
        .charIndex (romChar),
        .glyph     (romGlyph)
    );

    cursorPlacer placer (
        .clk_16ms (clk_16ms),
        .reset    (reset),
        .step     (placeStep.engine)
    );

    glyphRom rom (
        .image     (romImage),
        .charIndex (romChar),
        .glyph     (romGlyph)
    );

endmodule

// ==== sim/tbLcdTop.sv ====
module tbLcdTop;
    timeunit 1ns;
    timeprecision 1ps;

    import lcdPkg::*;
    import glyphPkg::*;

    logic       clk_16ms;
    logic       reset;
    logic       moodSel;
    logic       needSel;
    logic       rs;
    logic       rw;
    logic       enable;
    logic [7:0] data;

    // reference copy of the pattern memory
    glyph_t refGlyph [romWords];

    int caseMood[$];
    int caseNeed[$];
    int caseFrames[$];
    int errorCount;
    int checkCount;
    int totalFrames;
    bit casesLoaded;

    lcdTop UUT (
        .clk_16ms (clk_16ms),
        .reset    (reset),
        .moodSel  (moodSel),
        .needSel  (needSel),
        .rs       (rs),
        .rw       (rw),
        .enable   (enable),
        .data     (data)
    );

    initial begin
        clk_16ms = 1'b0;
        forever #5 clk_16ms = ~clk_16ms;
    end

    task automatic loadCases();
        int    fd;
        int    code;
        int    m;
        int    n;
        int    f;
        string line;
        fd = $fopen("sim/lcdCases.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/lcdCases.txt");
            errorCount++;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                // skip comment and blank lines
                if (code > 0 && line.len() > 0 && line[0] != "#") begin
                    if ($sscanf(line, "%d %d %d", m, n, f) == 3) begin
                        caseMood.push_back(m);
                        caseNeed.push_back(n);
                        caseFrames.push_back(f);
                        totalFrames += f;
                    end
                end
            end
            $fclose(fd);
        end
        casesLoaded = 1'b1;
    endtask

    // half 0 shows the mood, half 1 the need
    function automatic int imageForHalf(input int half, input int mood, input int need);
        if (half == 0) begin
            return (mood != 0) ? int'(imgHappy) : int'(imgSad);
        end
        return (need != 0) ? int'(imgFood) : int'(imgEnergy);
    endfunction

    // wait for the next bus byte, count the quiet cycles before it
    task automatic expectByte(input string what, input logic expRs,
                              input logic [7:0] expData, input int expGap);
        logic       gotRs;
        logic [7:0] gotData;
        int         gap;
        bit         found;
        gap     = 0;
        found   = 1'b0;
        gotRs   = 1'b0;
        gotData = 8'h00;
        while (!found && gap <= holdCycles + 5) begin
            @(negedge clk_16ms);
            if (rw !== 1'b0) begin
                $display("ERROR rw expected 0 got %h", rw);
                errorCount++;
            end
            if (enable === 1'b1) begin
                found   = 1'b1;
                gotRs   = rs;
                gotData = data;
            end else begin
                gap++;
            end
        end
        checkCount++;
        if (!found) begin
            $display("no bus byte within %0d cycles while waiting for %s", gap, what);
            errorCount++;
        end else begin
            if (gotData !== expData) begin
                $display("ERROR data expected %h got %h at %s", expData, gotData, what);
                errorCount++;
            end
            if (gotRs !== expRs) begin
                $display("ERROR rs expected %h got %h at %s", expRs, gotRs, what);
                errorCount++;
            end
            if (expGap >= 0 && gap != expGap) begin
                $display("enable was low for %0d cycles before %s, expected %0d",
                         gap, what, expGap);
                errorCount++;
            end
        end
    endtask

    // clear, CGRAM load of one image, display on, then the 4x2 block
    task automatic checkFrame(input int half, input int img, input int firstGap);
        glyph_t     g;
        logic [7:0] cmd;
        int         k;
        int         r;
        expectByte("frame clear", 1'b0, cmdClear, firstGap);
        for (k = 0; k < charsPerImage; k++) begin
            g = refGlyph[img * charsPerImage + k];
            expectByte("cgram address", 1'b0, cgramBase + 8'(8 * k), (k == 0) ? 1 : 0);
            for (r = 0; r < rowsPerChar; r++) begin
                expectByte("glyph row", 1'b1, g[8 * (7 - r) +: 8], 0);
            end
        end
        expectByte("display on", 1'b0, cmdDisplayOn, 0);
        for (k = 0; k < charsPerImage; k++) begin
            cmd = ((k < 4) ? ddramLine0 : ddramLine1) + 8'(k % 4);
            cmd = cmd + ((half == 1) ? halfColumn : 8'h00);
            expectByte("cursor command", 1'b0, cmd, 0);
            expectByte("character code", 1'b1, 8'(k), 0);
        end
    endtask

    // new selections go in one cycle into the hold
    task automatic driveSelect(input int mood, input int need);
        @(posedge clk_16ms);
        #1;
        moodSel = (mood != 0);
        needSel = (need != 0);
    endtask

    initial begin
        int c;
        int f;
        int frameNo;
        int firstGap;
        int caseStartErrors;
        reset       = 1'b0;
        moodSel     = 1'b0;
        needSel     = 1'b0;
        errorCount  = 0;
        checkCount  = 0;
        totalFrames = 0;
        $readmemh("verilog/glyphs.mem", refGlyph);
        loadCases();
        if (caseMood.size() > 0) begin
            moodSel = (caseMood[0] != 0);
            needSel = (caseNeed[0] != 0);
        end

        // four cycles of reset, bus must stay idle
        repeat (3) @(posedge clk_16ms);
        @(negedge clk_16ms);
        checkCount++;
        if (enable !== 1'b0) begin
            $display("ERROR enable expected 0 got %h", enable);
            errorCount++;
        end
        if (rs !== 1'b0) begin
            $display("ERROR rs expected 0 got %h", rs);
            errorCount++;
        end
        if (rw !== 1'b0) begin
            $display("ERROR rw expected 0 got %h", rw);
            errorCount++;
        end
        @(posedge clk_16ms);
        #1;
        reset = 1'b1;

        expectByte("function set", 1'b0, cmdFunctionSet, -1);
        expectByte("init display on", 1'b0, cmdDisplayOn, 0);
        expectByte("init clear", 1'b0, cmdClear, 0);

        firstGap = 0;
        frameNo  = 0;
        for (c = 0; c < caseMood.size(); c++) begin
            caseStartErrors = errorCount;
            if (c > 0) begin
                driveSelect(caseMood[c], caseNeed[c]);
            end
            for (f = 0; f < caseFrames[c]; f++) begin
                checkFrame(frameNo % 2, imageForHalf(frameNo % 2, caseMood[c], caseNeed[c]),
                           firstGap);
                firstGap = holdCycles;
                frameNo++;
            end
            $display("case %0d mood %0d need %0d frames %0d: %s", c, caseMood[c],
                     caseNeed[c], caseFrames[c],
                     (errorCount == caseStartErrors) ? "pass" : "fail");
        end

        if (caseMood.size() == 0) begin
            $display("no test cases were loaded");
            errorCount++;
        end else begin
            // last hold is closed by the next clear
            expectByte("clear after final hold", 1'b0, cmdClear, holdCycles);
        end

        $display("%0d cases, %0d checks, %0d errors", caseMood.size(), checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // run limit scales with the frames the cases ask for
    initial begin
        int limit;
        wait (casesLoaded);
        limit = totalFrames * (90 + holdCycles + 10) + 100;
        repeat (limit) @(posedge clk_16ms);
        $display("timeout, run did not finish within %0d cycles", limit);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== verilog/glyphs.mem ====
// one character per line as a 64-bit word, row 0 in the top byte
// images in ROM order: sad cat, happy cat, energy, food
// sad cat
000103070F0F1F1F
0010181C1F1F1F1F
000103071F1F1F1F
0010181C1E1E1F1F
1F1B1F1F1E1D0F07
1F1F1F110E1F1F1F
1F1F1F0E111F1F1F
1F1B1F1F0F171E1C
// happy cat
00000103070F1F1F
0000101C1E1F1F1F
000001070F1F1F1F
000010181C1E1F1F
1F1B1F1F1F1E0F07
1F1F1F1F110E1F1F
1F1F1F1F1B0E1F1F
1F1B1F1F1F0F1E1C
// energy
00070F1F1F1F1F1F
001F1F1F1E1C181F
001F1F0F0703011F
001C1E1F1F1F1F1E
1F1F1F1F1F0F0700
1F1F1F1F1F1F1F00
1F1F1F1F1F1F1F01
1E1F1F1F1F1E1C00
// food
0000000001030707
000E1F1F1F1F1F1F
000E1F1F1F1F1F1E
0000000010181C1C
1F1F0F0703010000
1F1F1F1F1F1F0E00
1F1F1F1F1F1F0E01
1F1F1E1C18100000

// ==== sim/lcdCases.txt ====
# columns: moodSel needSel frames (decimal)
# frames count both halves, half 0 shows the mood image and half 1 the need image
0 0 2
1 0 2
1 1 3
0 1 2
1 1 1
0 0 3
1 0 1

// ==== vlog.f ====
verilog/lcdPkg.sv
verilog/glyphPkg.sv
verilog/lcdStepIf.sv
verilog/glyphRom.sv
verilog/cgramLoader.sv
verilog/cursorPlacer.sv
verilog/lcdSequencer.sv
verilog/lcdTop.sv
sim/tbLcdTop.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the LCD controller testbench with Verilator
set -e
cd "$(dirname "$0")"

# the glyph ROM loads glyphs.mem from the working directory
cp -f verilog/glyphs.mem glyphs.mem

verilator --binary --timing --assert -Wno-fatal --top-module tbLcdTop -f vlog.f -o tbLcdTop

# the log decides pass or fail
./obj_dir/tbLcdTop > sim.log 2>&1 || true
cat sim.log
grep -qx "Test OK" sim.log
